// File: verilog/adc_rx_pkg.sv
package adc_rx_pkg;

    localparam int WORD_W            = 8;   // deserializer ratio
    localparam int SAMPLE_W          = 14;  // adc resolution
    localparam int SLIP_W            = 4;
    localparam int NUM_CHANNELS      = 2;
    localparam int LANES_PER_CHANNEL = 2;   // two-lane mode, msb lane first

    // padding bits below each sample, 16 - 14
    localparam int PAD_W = LANES_PER_CHANNEL * WORD_W - SAMPLE_W;

    typedef logic [WORD_W-1:0]   word_t;      // one lane word per clk_div
    typedef logic [SLIP_W-1:0]   slip_t;      // 0..7 offset, 15 unknown
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [2*WORD_W-1:0] word_join_t; // two words side by side

    localparam word_t      FRAME_PATTERN = 8'b0000_1111; // frame word at offset 0
    localparam slip_t      SLIP_UNKNOWN  = 4'd15;
    localparam logic [2:0] SETTLE_CYCLES = 3'd4;         // enabled edges before frame_valid
    localparam logic [1:0] STABLE_CYCLES = 2'd3;         // unchanged offset updates

    typedef struct packed {
        word_t msb;  // upper lane of the channel
        word_t lsb;
    } lane_pair_t;

    typedef struct packed {
        lane_pair_t [NUM_CHANNELS-1:0] ch;
    } lane_words_t;

    typedef struct packed {
        sample_t [NUM_CHANNELS-1:0] ch;
    } sample_bus_t;

endpackage

// File: verilog/frame_settle.sv
`timescale 1ns/1ps

module frame_settle (
    input  logic clk_div,
    input  logic reset,
    input  logic enable,
    output logic frame_valid
);

    // deserializer needs a few word clocks after enable before
    // the frame lane can be trusted
    logic [2:0] settle_cnt; // enabled edges seen, saturating

    always_ff @(posedge clk_div or posedge reset) begin
        if (reset) begin
            settle_cnt  <= '0;
            frame_valid <= 1'b0;
        end else if (enable) begin
            if (settle_cnt != adc_rx_pkg::SETTLE_CYCLES) begin
                settle_cnt  <= settle_cnt + 3'd1; // still settling
                frame_valid <= 1'b0;
            end else begin
                frame_valid <= 1'b1;              // settled, stays up while enabled
            end
        end else begin
            frame_valid <= 1'b0;                  // count frozen, valid dropped
        end
    end

    // a disabled cycle always costs the next cycle's valid
    a_valid_after_disable : assert property (
        @(posedge clk_div) disable iff (reset)
        !enable |=> !frame_valid
    ) else $error("frame_valid high right after enable was low");

endmodule

// File: verilog/bitslip_detect.sv
`timescale 1ns/1ps

module bitslip_detect (
    input  logic              clk_div,
    input  logic              reset,
    input  logic              enable,
    input  adc_rx_pkg::word_t frame_word,
    output adc_rx_pkg::slip_t bitslip_count,
    output logic              slip_stable
);

    adc_rx_pkg::word_t stage_one;   // frame word, first register
    adc_rx_pkg::word_t stage_two;   // second register, fed to decoder
    adc_rx_pkg::slip_t slip_next;   // decoded offset of stage_two
    logic [1:0]        stable_cnt;  // updates with same known offset

    // frame pattern as seen at capture offset k
    function automatic adc_rx_pkg::word_t rotl_pattern(input int unsigned k);
        adc_rx_pkg::word_join_t doubled;
        doubled = {adc_rx_pkg::FRAME_PATTERN, adc_rx_pkg::FRAME_PATTERN} << k;
        return doubled[2*adc_rx_pkg::WORD_W-1 -: adc_rx_pkg::WORD_W];
    endfunction

    always_comb begin
        slip_next = adc_rx_pkg::SLIP_UNKNOWN; // anything but a rotation
        for (int i = 0; i < adc_rx_pkg::WORD_W; i++) begin
            if (stage_two == rotl_pattern(i)) begin
                slip_next = adc_rx_pkg::slip_t'(i);
            end
        end
    end

    always_ff @(posedge clk_div or posedge reset) begin
        if (reset) begin
            stage_one     <= '0;
            stage_two     <= '0;
            bitslip_count <= '0;
            stable_cnt    <= '0;
        end else if (enable) begin
            stage_one     <= frame_word;
            stage_two     <= stage_one;
            bitslip_count <= slip_next;
            if (slip_next != adc_rx_pkg::SLIP_UNKNOWN && slip_next == bitslip_count) begin
                if (stable_cnt != adc_rx_pkg::STABLE_CYCLES) begin
                    stable_cnt <= stable_cnt + 2'd1; // saturates
                end
            end else begin
                stable_cnt <= '0;                    // changed or lost the pattern
            end
        end
    end

    assign slip_stable = (stable_cnt == adc_rx_pkg::STABLE_CYCLES);

    // counter and offset register must agree across updates
    a_stable_known : assert property (
        @(posedge clk_div) disable iff (reset)
        slip_stable |-> bitslip_count != adc_rx_pkg::SLIP_UNKNOWN
    ) else $error("slip_stable high with unknown offset");

endmodule

// File: verilog/lane_aligner.sv
`timescale 1ns/1ps

module lane_aligner (
    input  logic                    clk_div,
    input  logic                    reset,
    input  logic                    enable,
    input  adc_rx_pkg::lane_words_t lane_words,
    input  adc_rx_pkg::slip_t       bitslip_count,
    output adc_rx_pkg::lane_words_t aligned_words
);

    // captured word n holds the top bits of true word n and the
    // leftover of word n-1, so word n comes back out of C(n+1):C(n)
    adc_rx_pkg::lane_words_t cur_q;        // latest captured words
    adc_rx_pkg::lane_words_t prev_q;       // one word older
    adc_rx_pkg::lane_words_t aligned_next;

    // 8-bit window at offset k out of newer:older
    function automatic adc_rx_pkg::word_t window(
        input adc_rx_pkg::word_t newer,
        input adc_rx_pkg::word_t older,
        input adc_rx_pkg::slip_t k
    );
        adc_rx_pkg::word_join_t joined;
        joined = {newer, older};
        if (k == adc_rx_pkg::SLIP_UNKNOWN) begin
            return older; // no offset, hand the word on as is
        end
        return joined[k[2:0] +: adc_rx_pkg::WORD_W];
    endfunction

    always_comb begin
        for (int c = 0; c < adc_rx_pkg::NUM_CHANNELS; c++) begin
            aligned_next.ch[c].msb = window(cur_q.ch[c].msb, prev_q.ch[c].msb,
                                            bitslip_count);
            aligned_next.ch[c].lsb = window(cur_q.ch[c].lsb, prev_q.ch[c].lsb,
                                            bitslip_count);
        end
    end

    always_ff @(posedge clk_div or posedge reset) begin
        if (reset) begin
            cur_q         <= '0;
            prev_q        <= '0;
            aligned_words <= '0;
        end else if (enable) begin
            cur_q         <= lane_words;   // C(n+1) once the next word lands
            prev_q        <= cur_q;        // C(n)
            aligned_words <= aligned_next; // T(n), offset as registered now
        end
    end

endmodule

// File: verilog/sample_assembler.sv
`timescale 1ns/1ps

module sample_assembler (
    input  logic                    clk_div,
    input  logic                    reset,
    input  logic                    enable,
    input  adc_rx_pkg::lane_words_t aligned_words,
    input  logic                    frame_valid,
    input  logic                    slip_stable,
    output adc_rx_pkg::sample_bus_t samples,
    output logic                    sample_valid
);

    adc_rx_pkg::sample_bus_t samples_next;

    // msb lane above lsb lane, bottom bits are adc padding
    function automatic adc_rx_pkg::sample_t join_sample(input adc_rx_pkg::lane_pair_t pair);
        adc_rx_pkg::word_join_t joined;
        joined = {pair.msb, pair.lsb};
        return joined[2*adc_rx_pkg::WORD_W-1 : adc_rx_pkg::PAD_W];
    endfunction

    always_comb begin
        for (int c = 0; c < adc_rx_pkg::NUM_CHANNELS; c++) begin
            samples_next.ch[c] = join_sample(aligned_words.ch[c]);
        end
    end

    always_ff @(posedge clk_div or posedge reset) begin
        if (reset) begin
            samples      <= '0;
            sample_valid <= 1'b0;
        end else if (enable) begin
            samples      <= samples_next;
            sample_valid <= frame_valid && slip_stable; // in step with samples
        end else begin
            sample_valid <= 1'b0; // drops with frame_valid, samples hold
        end
    end

    // valid only ever follows a settled frame lane
    a_valid_needs_frame : assert property (
        @(posedge clk_div) disable iff (reset)
        !frame_valid |-> !sample_valid
    ) else $error("sample_valid high while frame_valid low");

endmodule

// File: verilog/adc_frame_rx.sv
`timescale 1ns/1ps

module adc_frame_rx (
    input  logic                    clk_div,
    input  logic                    reset,
    input  logic                    enable,
    input  adc_rx_pkg::word_t       frame_word,
    input  adc_rx_pkg::lane_words_t lane_words,
    output logic                    frame_valid,
    output adc_rx_pkg::slip_t       bitslip_count,
    output adc_rx_pkg::sample_bus_t samples,
    output logic                    sample_valid
);

    logic                    slip_stable;   // offset held long enough
    adc_rx_pkg::lane_words_t aligned_words; // lanes back on word boundaries

    // enable settling of the frame lane
    frame_settle u_frame_settle (
        .clk_div     (clk_div),
        .reset       (reset),
        .enable      (enable),
        .frame_valid (frame_valid)
    );

    // capture offset from the frame pattern rotation
    bitslip_detect u_bitslip_detect (
        .clk_div       (clk_div),
        .reset         (reset),
        .enable        (enable),
        .frame_word    (frame_word),
        .bitslip_count (bitslip_count),
        .slip_stable   (slip_stable)
    );

    // realign every data lane by that offset
    lane_aligner u_lane_aligner (
        .clk_div       (clk_div),
        .reset         (reset),
        .enable        (enable),
        .lane_words    (lane_words),
        .bitslip_count (bitslip_count),
        .aligned_words (aligned_words)
    );

    // lane pairs into channel samples
    sample_assembler u_sample_assembler (
        .clk_div       (clk_div),
        .reset         (reset),
        .enable        (enable),
        .aligned_words (aligned_words),
        .frame_valid   (frame_valid),
        .slip_stable   (slip_stable),
        .samples       (samples),
        .sample_valid  (sample_valid)
    );

endmodule

// File: include/tb_adc_model.svh
`ifndef TB_ADC_MODEL_SVH
`define TB_ADC_MODEL_SVH

// serial capture model of the adc lanes
adc_rx_pkg::lane_words_t prev_true;       // last true word of every lane
adc_rx_pkg::sample_bus_t hist_samples[$]; // true samples, one entry per word
int                      hist_segment[$]; // segment number, -1 in gaps

// upper byte of newer:older shifted left by k
function automatic adc_rx_pkg::word_t capture(input adc_rx_pkg::word_t newer,
                                              input adc_rx_pkg::word_t older,
                                              input int unsigned k);
    adc_rx_pkg::word_join_t joined;
    joined = {newer, older} << k;
    return joined[2*adc_rx_pkg::WORD_W-1 -: adc_rx_pkg::WORD_W];
endfunction

// one word of stimulus at offset k, a negative segment means gap with zero frame lane
function automatic void next_word(input  adc_rx_pkg::sample_bus_t truth,
                                  input  int                      segment,
                                  input  int unsigned             k,
                                  output adc_rx_pkg::word_t       frame_word,
                                  output adc_rx_pkg::lane_words_t lane_words);
    adc_rx_pkg::lane_words_t true_words;
    adc_rx_pkg::word_join_t  padded;
    for (int c = 0; c < adc_rx_pkg::NUM_CHANNELS; c++) begin
        padded = {truth.ch[c], {adc_rx_pkg::PAD_W{1'b0}}};
        true_words.ch[c].msb = padded[2*adc_rx_pkg::WORD_W-1 -: adc_rx_pkg::WORD_W];
        true_words.ch[c].lsb = padded[adc_rx_pkg::WORD_W-1:0];
        lane_words.ch[c].msb = capture(true_words.ch[c].msb, prev_true.ch[c].msb, k);
        lane_words.ch[c].lsb = capture(true_words.ch[c].lsb, prev_true.ch[c].lsb, k);
    end
    frame_word = (segment < 0) ? '0 :
        capture(adc_rx_pkg::FRAME_PATTERN, adc_rx_pkg::FRAME_PATTERN, k);
    prev_true = true_words;
    hist_samples.push_back(truth);
    hist_segment.push_back(segment);
endfunction

`endif

// File: test/tb_adc_frame_rx.sv
`timescale 1ns/1ps

module tb_adc_frame_rx;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 4;
    localparam int          NUM_SEGMENTS = 12;  // first 8 cover every offset
    localparam int          GAP_WORDS    = 4;   // zero frame words between segments
    localparam int          MIN_SEG      = 30;
    localparam int          MAX_SEG      = 60;
    localparam int          WATCH_MARGIN = 100; // spare cycles for the watchdog
    localparam logic [31:0] SEED         = 32'h8b5e_a180;

    logic                    clk_div;
    logic                    reset;
    logic                    enable;
    adc_rx_pkg::word_t       frame_word;
    adc_rx_pkg::lane_words_t lane_words;
    logic                    frame_valid;
    adc_rx_pkg::slip_t       bitslip_count;
    adc_rx_pkg::sample_bus_t samples;
    logic                    sample_valid;

    adc_rx_pkg::word_t       stim_frame[$];  // frame lane, one per word
    adc_rx_pkg::lane_words_t stim_lanes[$];  // captured data lanes
    int                      stim_k[$];      // offset the word was captured at
    int                      stim_depth[$];  // words before it in its segment, -1 in gaps
    int                      stim_pause[$];  // disabled cycles ahead of the word
    int                      total_cycles;
    bit                      stim_ready;

    logic                    exp_frame_valid; // expected outputs after the last edge
    logic                    exp_sample_valid;
    adc_rx_pkg::slip_t       exp_slip;
    adc_rx_pkg::sample_bus_t exp_samples;
    int                      settle_seen;     // enabled edges counted toward settling
    int                      en_edges;        // enabled edges since reset

`include "tb_adc_model.svh"

    adc_frame_rx u_adc_frame_rx (
        .clk_div       (clk_div),
        .reset         (reset),
        .enable        (enable),
        .frame_word    (frame_word),
        .lane_words    (lane_words),
        .frame_valid   (frame_valid),
        .bitslip_count (bitslip_count),
        .samples       (samples),
        .sample_valid  (sample_valid)
    );

    always #(CLK_PERIOD / 2) clk_div = ~clk_div;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one word through the capture model, queued for driving
    task automatic add_word(input int seg, input int k, input int depth, input int pause);
        adc_rx_pkg::sample_bus_t truth;
        adc_rx_pkg::word_t       fw;
        adc_rx_pkg::lane_words_t lw;
        for (int c = 0; c < adc_rx_pkg::NUM_CHANNELS; c++) begin
            truth.ch[c] = adc_rx_pkg::sample_t'($urandom); // random 14-bit sample
        end
        next_word(truth, seg, k, fw, lw);
        stim_frame.push_back(fw);
        stim_lanes.push_back(lw);
        stim_k.push_back(k);
        stim_depth.push_back(depth);
        stim_pause.push_back(pause);
        total_cycles += 1 + pause;
    endtask

    task automatic build_stimulus();
        int order[8];
        int pick;
        int tmp;
        int k;
        int len;
        int pause_word;
        int pause_len;
        for (int i = 0; i < 8; i++) begin
            order[i] = i;
        end
        for (int i = 7; i > 0; i--) begin // shuffle so all offsets show up early
            pick        = int'($urandom % (i + 1));
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        for (int g = 0; g < GAP_WORDS; g++) begin
            add_word(-1, 0, -1, 0);       // lead-in gap
        end
        for (int s = 0; s < NUM_SEGMENTS; s++) begin
            k          = (s < 8) ? order[s] : int'($urandom % 8);
            len        = MIN_SEG + int'($urandom % (MAX_SEG - MIN_SEG + 1));
            pause_word = -1;
            pause_len  = 1 + int'($urandom % 4);
            if (s == 2 || s == 9) begin
                pause_word = 5 + int'($urandom % (len - 10)); // enable drop mid segment
            end
            for (int w = 0; w < len; w++) begin
                add_word(s, k, w, (w == pause_word) ? pause_len : 0);
            end
            for (int g = 0; g < GAP_WORDS; g++) begin
                add_word(-1, k, -1, 0);   // offset kept, frame lane all zero
            end
        end
    endtask

    // expected outputs after one rising edge
    task automatic predict_edge(input bit en);
        int j;
        if (en) begin
            j = en_edges;                 // word j sampled at this edge
            exp_sample_valid = 1'b0;
            if (j >= 3) begin
                exp_samples = hist_samples[j - 3];
                if (exp_frame_valid &&
                    stim_depth[j - 3] >= int'(adc_rx_pkg::STABLE_CYCLES)) begin
                    exp_sample_valid = 1'b1;
                end
            end
            exp_slip = adc_rx_pkg::SLIP_UNKNOWN;
            if (j >= 2 && hist_segment[j - 2] >= 0) begin
                exp_slip = adc_rx_pkg::slip_t'(stim_k[j - 2]);
            end
            if (settle_seen >= int'(adc_rx_pkg::SETTLE_CYCLES)) begin
                exp_frame_valid = 1'b1;
            end else begin
                settle_seen++;
                exp_frame_valid = 1'b0;
            end
            en_edges++;
        end else begin
            exp_frame_valid  = 1'b0;      // pipeline frozen, valids drop
            exp_sample_valid = 1'b0;
        end
    endtask

    task automatic check_outputs();
        check_value("frame_valid", 32'(frame_valid), 32'(exp_frame_valid));
        check_value("bitslip_count", 32'(bitslip_count), 32'(exp_slip));
        check_value("sample_valid", 32'(sample_valid), 32'(exp_sample_valid));
        if (exp_sample_valid) begin
            for (int c = 0; c < adc_rx_pkg::NUM_CHANNELS; c++) begin
                check_value($sformatf("samples.ch[%0d]", c), 32'(samples.ch[c]),
                            32'(exp_samples.ch[c]));
            end
        end
    endtask

    initial begin
        int  n_drive;
        int  pause_cnt;
        bit  applied_en;
        clk_div          = 1'b0;
        reset            = 1'b1;
        enable           = 1'b0;
        frame_word       = '0;
        lane_words       = '0;
        stim_ready       = 1'b0;
        total_cycles     = RESET_CYCLES;
        void'($urandom(SEED));
        prev_true        = '0;
        build_stimulus();
        stim_ready       = 1'b1;
        exp_frame_valid  = 1'b0;           // reset values
        exp_sample_valid = 1'b0;
        exp_slip         = '0;
        exp_samples      = '0;
        settle_seen      = 0;
        en_edges         = 0;

        @(posedge clk_div);
        @(negedge clk_div);
        check_outputs();
        check_value("samples", 32'(samples), 32'(0));
        repeat (RESET_CYCLES - 1) @(posedge clk_div);
        reset      <= 1'b0;
        enable     <= 1'b1;
        frame_word <= stim_frame[0];
        lane_words <= stim_lanes[0];
        n_drive    = 1;
        pause_cnt  = 0;
        applied_en = 1'b1;

        while (en_edges < stim_frame.size()) begin
            @(posedge clk_div);
            predict_edge(applied_en);      // edge just taken
            if (n_drive < stim_frame.size()) begin
                if (pause_cnt < stim_pause[n_drive]) begin
                    enable     <= 1'b0;    // inputs held while disabled
                    pause_cnt++;
                    applied_en = 1'b0;
                end else begin
                    enable     <= 1'b1;
                    frame_word <= stim_frame[n_drive];
                    lane_words <= stim_lanes[n_drive];
                    n_drive++;
                    pause_cnt  = 0;
                    applied_en = 1'b1;
                end
            end
            @(negedge clk_div);
            check_outputs();
        end

        $display("All checks passed");
        $finish;
    end

    // stimulus length plus margin, then give up
    initial begin
        wait (stim_ready);
        repeat (total_cycles + WATCH_MARGIN) @(posedge clk_div);
        $display("Timeout: run still going after %0d clock cycles", total_cycles + WATCH_MARGIN);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: src.f
+incdir+include
verilog/adc_rx_pkg.sv
verilog/frame_settle.sv
verilog/bitslip_detect.sv
verilog/lane_aligner.sv
verilog/sample_assembler.sv
verilog/adc_frame_rx.sv
test/tb_adc_frame_rx.sv

// File: Makefile
# Verilator build of the ADC frame receiver testbench.
# Any variable below can be overridden on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP       ?= tb_adc_frame_rx
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
